//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= verilog.f
TB_TOP    ?= dcache_tb
RTL_TOP   ?= dcache_top
OBJ_DIR   ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing -j $(JOBS)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TB_TOP)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- bench/dcache_mem_model.sv
// memory bus responder
module dcache_mem_model (
  input  logic        clk,
  input  logic        rst,
  input  logic        mem_ar_valid_i,
  output logic        mem_ar_ready_o,
  input  logic [31:0] mem_ar_addr_i,
  output logic        mem_r_valid_o,
  input  logic        mem_r_ready_i,
  output logic [63:0] mem_r_data_o,
  input  logic        mem_aw_valid_i,
  output logic        mem_aw_ready_o,
  input  logic [31:0] mem_aw_addr_i,
  input  logic        mem_w_valid_i,
  output logic        mem_w_ready_o,
  input  logic [7:0]  mem_w_strb_i,
  input  logic [63:0] mem_w_data_i,
  output logic        mem_b_valid_o,
  input  logic        mem_b_ready_i
);

  logic [63:0] mem_q [logic [28:0]];  // only words written back, keyed by word address
  logic [31:0] seed = 32'ha549_fd81;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // untouched words read as {address, ~address}
  function automatic logic [63:0] read_word(input logic [31:0] addr);
    logic [31:0] wa;
    wa = {addr[31:3], 3'b000};
    if (mem_q.exists(wa[31:3])) begin
      return mem_q[wa[31:3]];
    end
    return {wa, ~wa};
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic stall();
    seed = lcg_next(seed);
    repeat (seed[17:16]) next_cycle();  // 0 to 3 idle cycles
  endtask

  task automatic serve_read();
    logic [31:0] base;
    stall();
    base = mem_ar_addr_i;
    mem_ar_ready_o = 1'b1;
    next_cycle();
    mem_ar_ready_o = 1'b0;
    for (int beat = 0; beat < 2; beat++) begin
      stall();
      mem_r_valid_o = 1'b1;
      mem_r_data_o  = read_word(base + 32'(beat * 8));  // lower beat first
      while (!mem_r_ready_i) next_cycle();
      next_cycle();
      mem_r_valid_o = 1'b0;
    end
  endtask

  task automatic serve_write();
    logic [31:0] base;
    logic [63:0] word;
    stall();
    base = mem_aw_addr_i;
    mem_aw_ready_o = 1'b1;
    next_cycle();
    mem_aw_ready_o = 1'b0;
    for (int beat = 0; beat < 2; beat++) begin
      stall();
      mem_w_ready_o = 1'b1;
      while (!mem_w_valid_i) next_cycle();
      word = read_word(base + 32'(beat * 8));
      for (int b = 0; b < 8; b++) begin
        if (mem_w_strb_i[b]) begin
          word[b*8 +: 8] = mem_w_data_i[b*8 +: 8];
        end
      end
      mem_q[base[31:3] + 29'(beat)] = word;
      next_cycle();
      mem_w_ready_o = 1'b0;
    end
    stall();
    mem_b_valid_o = 1'b1;
    while (!mem_b_ready_i) next_cycle();
    next_cycle();
    mem_b_valid_o = 1'b0;
  endtask

  initial begin
    mem_ar_ready_o = 1'b0;
    mem_r_valid_o  = 1'b0;
    mem_r_data_o   = '0;
    mem_aw_ready_o = 1'b0;
    mem_w_ready_o  = 1'b0;
    mem_b_valid_o  = 1'b0;
    forever begin
      next_cycle();
      if (!rst && mem_ar_valid_i) begin
        serve_read();
      end else if (!rst && mem_aw_valid_i) begin
        serve_write();
      end
    end
  end

endmodule

//--- bench/dcache_stim.txt
// op addr strb wdata expected hit
// hit 1 must hit, 0 must miss, 2 either way after random eviction
rd 00001000 00 0000000000000000 00001000ffffefff 0
rd 00001008 00 0000000000000000 00001008ffffeff7 1
rd 00001000 00 0000000000000000 00001000ffffefff 1
wr 00001008 0f 1122334455667788 0000000000000000 1
rd 00001008 00 0000000000000000 0000100855667788 1
wr 00002010 f0 aabbccddeeff0011 0000000000000000 0
rd 00002010 00 0000000000000000 aabbccddffffdfef 1
rd 00002018 00 0000000000000000 00002018ffffdfe7 1
wr 00002018 81 0102030405060708 0000000000000000 1
rd 00002018 00 0000000000000000 01002018ffffdf08 1
wr 00010020 ff a0a0a0a0a0a0a0a0 0000000000000000 0
wr 00020028 ff b1b1b1b1b1b1b1b1 0000000000000000 0
wr 00030020 0f c2c2c2c2c2c2c2c2 0000000000000000 0
rd 00010020 00 0000000000000000 a0a0a0a0a0a0a0a0 2
rd 00020028 00 0000000000000000 b1b1b1b1b1b1b1b1 2
rd 00020020 00 0000000000000000 00020020fffdffdf 2
rd 00030020 00 0000000000000000 00030020c2c2c2c2 2
rd 00030028 00 0000000000000000 00030028fffcffd7 2
wr 00010028 3c 1122334455667788 0000000000000000 2
rd 00040020 00 0000000000000000 00040020fffbffdf 0
rd 00050020 00 0000000000000000 00050020fffaffdf 0
rd 00010028 00 0000000000000000 000133445566ffd7 2
rd 00010020 00 0000000000000000 a0a0a0a0a0a0a0a0 2
rd 00020028 00 0000000000000000 b1b1b1b1b1b1b1b1 2
rd 00030020 00 0000000000000000 00030020c2c2c2c2 2
rd 00001008 00 0000000000000000 0000100855667788 1
rd 00002018 00 0000000000000000 01002018ffffdf08 1
rd 00011000 00 0000000000000000 00011000fffeefff 0
rd 00011000 00 0000000000000000 00011000fffeefff 1

//--- bench/dcache_tb.sv
// data cache testbench
module dcache_tb;

  localparam int    CLK_PERIOD    = 10;
  localparam int    RST_CYCLES    = 8;
  localparam int    CYCLES_PER_OP = 200;
  localparam string STIM_FILE     = "bench/dcache_stim.txt";

  logic        clk = 1'b0;
  logic        rst;
  // cpu side, named as the DUT ports
  logic        ar_valid_i, ar_ready_o, r_valid_o, r_ready_i;
  logic [31:0] ar_addr_i, aw_addr_i;
  logic [63:0] r_data_o, w_data_i;
  logic        aw_valid_i, aw_ready_o, w_valid_i, w_ready_o, b_valid_o, b_ready_i;
  logic [7:0]  w_strb_i;
  // memory side
  logic        mem_ar_valid_o, mem_ar_ready_i, mem_r_valid_i, mem_r_ready_o;
  logic        mem_aw_valid_o, mem_aw_ready_i, mem_w_valid_o, mem_w_ready_i;
  logic        mem_b_valid_i, mem_b_ready_o;
  logic [31:0] mem_ar_addr_o, mem_aw_addr_o;
  logic [63:0] mem_r_data_i, mem_w_data_o;
  logic [7:0]  mem_w_strb_o;

  // stimulus table
  logic [15:0] op_list[$];
  logic [31:0] addr_list[$];
  logic [7:0]  strb_list[$];
  logic [63:0] wdata_list[$];
  logic [63:0] exp_list[$];
  int          hit_list[$];
  int          n_ops;
  logic        loaded = 1'b0;
  int          ar_xfers;  // memory refills seen

  always #(CLK_PERIOD / 2) clk = ~clk;

  dcache_top i_dut (.*);

  dcache_mem_model i_mem (
    .clk            (clk),
    .rst            (rst),
    .mem_ar_valid_i (mem_ar_valid_o),
    .mem_ar_ready_o (mem_ar_ready_i),
    .mem_ar_addr_i  (mem_ar_addr_o),
    .mem_r_valid_o  (mem_r_valid_i),
    .mem_r_ready_i  (mem_r_ready_o),
    .mem_r_data_o   (mem_r_data_i),
    .mem_aw_valid_i (mem_aw_valid_o),
    .mem_aw_ready_o (mem_aw_ready_i),
    .mem_aw_addr_i  (mem_aw_addr_o),
    .mem_w_valid_i  (mem_w_valid_o),
    .mem_w_ready_o  (mem_w_ready_i),
    .mem_w_strb_i   (mem_w_strb_o),
    .mem_w_data_i   (mem_w_data_o),
    .mem_b_valid_o  (mem_b_valid_i),
    .mem_b_ready_i  (mem_b_ready_o)
  );

  always @(posedge clk) begin
    if (rst) begin
      ar_xfers <= 0;
    end else if (mem_ar_valid_o && mem_ar_ready_i) begin
      ar_xfers <= ar_xfers + 1;
    end
  end

  // writeback beats carry the whole word
  always @(posedge clk) begin
    if (!rst && mem_w_valid_o && mem_w_ready_i) begin
      check_equal("mem_w_strb_o", 64'(mem_w_strb_o), 64'hff);
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("FAIL: see errors above");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_equal(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    if (got !== exp) begin
      $display("Error: time %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("stopping at the first mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  // flag 1 must hit, 0 must miss, 2 depends on the victim pick
  task automatic check_hit(input int flag, input int cycles, input int fills);
    if (flag == 1) begin
      check_equal("response latency", 64'(cycles), 64'd2);
      check_equal("mem ar transfers", 64'(fills), 64'd0);
    end else if (flag == 0) begin
      check_equal("mem ar transfers", 64'(fills), 64'd1);
    end
  endtask

  task automatic load_stim();
    int               fd;
    int               code;
    logic [15:0]      op;
    logic [31:0]      addr;
    logic [7:0]       strb;
    logic [63:0]      wdata;
    logic [63:0]      exp;
    int               hit;
    logic [8*120-1:0] rest;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("cannot open the stimulus file");
    end else begin
      while ($fscanf(fd, " %s", op) == 1) begin
        if (op == "//") begin
          code = $fgets(rest, fd);
        end else begin
          code = $fscanf(fd, " %h %h %h %h %d", addr, strb, wdata, exp, hit);
          if (code != 5 || (op != "rd" && op != "wr")) begin
            abort_run("the stimulus file has a malformed line");
          end else begin
            op_list.push_back(op);
            addr_list.push_back(addr);
            strb_list.push_back(strb);
            wdata_list.push_back(wdata);
            exp_list.push_back(exp);
            hit_list.push_back(hit);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_reset_outputs();
    check_equal("ar_ready_o", 64'(ar_ready_o), 64'd0);
    check_equal("aw_ready_o", 64'(aw_ready_o), 64'd0);
    check_equal("r_valid_o", 64'(r_valid_o), 64'd0);
    check_equal("w_ready_o", 64'(w_ready_o), 64'd0);
    check_equal("b_valid_o", 64'(b_valid_o), 64'd0);
    check_equal("mem_ar_valid_o", 64'(mem_ar_valid_o), 64'd0);
    check_equal("mem_aw_valid_o", 64'(mem_aw_valid_o), 64'd0);
    check_equal("mem_w_valid_o", 64'(mem_w_valid_o), 64'd0);
  endtask

  task automatic run_read(input int idx);
    int cycles;
    int xfers;
    ar_valid_i = 1'b1;
    ar_addr_i  = addr_list[idx];
    while (!ar_ready_o) next_cycle();
    xfers = ar_xfers;
    next_cycle();  // ar transfer
    ar_valid_i = 1'b0;
    cycles = 0;
    while (!r_valid_o) begin
      next_cycle();
      cycles++;
    end
    check_equal("r_data_o", r_data_o, exp_list[idx]);
    repeat (idx % 3 + 1) begin  // back-pressure
      next_cycle();
      check_equal("r_valid_o", 64'(r_valid_o), 64'd1);
    end
    r_ready_i = 1'b1;
    next_cycle();
    r_ready_i = 1'b0;
    check_equal("r_valid_o", 64'(r_valid_o), 64'd0);
    check_hit(hit_list[idx], cycles, ar_xfers - xfers);
  endtask

  task automatic run_write(input int idx);
    int cycles;
    int xfers;
    aw_valid_i = 1'b1;
    aw_addr_i  = addr_list[idx];
    while (!aw_ready_o) next_cycle();
    xfers = ar_xfers;
    next_cycle();
    aw_valid_i = 1'b0;
    cycles = 0;
    while (!w_ready_o) begin
      next_cycle();
      cycles++;
    end
    w_valid_i = 1'b1;
    w_strb_i  = strb_list[idx];
    w_data_i  = wdata_list[idx];
    next_cycle();  // w transfer
    w_valid_i = 1'b0;
    check_equal("b_valid_o", 64'(b_valid_o), 64'd1);
    repeat (idx % 3) begin
      next_cycle();
      check_equal("b_valid_o", 64'(b_valid_o), 64'd1);
    end
    b_ready_i = 1'b1;
    next_cycle();
    b_ready_i = 1'b0;
    check_equal("b_valid_o", 64'(b_valid_o), 64'd0);
    check_hit(hit_list[idx], cycles, ar_xfers - xfers);
  endtask

  initial begin
    rst        = 1'b1;
    ar_valid_i = 1'b0;
    ar_addr_i  = '0;
    r_ready_i  = 1'b0;
    aw_valid_i = 1'b0;
    aw_addr_i  = '0;
    w_valid_i  = 1'b0;
    w_strb_i   = '0;
    w_data_i   = '0;
    b_ready_i  = 1'b0;
    load_stim();
    n_ops  = op_list.size();
    loaded = 1'b1;
    repeat (RST_CYCLES) begin
      next_cycle();
      check_reset_outputs();
    end
    rst = 1'b0;
    for (int i = 0; i < n_ops; i++) begin
      if (op_list[i] == "rd") begin
        run_read(i);
      end else begin
        run_write(i);
      end
    end
    if (n_ops > 0) begin
      $display("PASS: all tests");
      $finish;
    end else begin
      abort_run("the stimulus file holds no operations");
    end
  end

  // watchdog
  initial begin
    wait (loaded);
    repeat (RST_CYCLES + CYCLES_PER_OP * n_ops) @(posedge clk);
    abort_run("timeout, the cache stopped responding");
  end

endmodule

//--- design/dcache_front.sv
// cpu request front end
module dcache_front (
  input  logic                            clk,
  input  logic                            rst,
  // read address / data
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0]   ar_addr_i,
  output logic                            r_valid_o,
  input  logic                            r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0]   r_data_o,
  // write address / data / response
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0]   aw_addr_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  input  logic [dcache_pkg::STRB_W-1:0]   w_strb_i,
  input  logic [dcache_pkg::DATA_W-1:0]   w_data_i,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  // store
  output logic                            lookup_o,
  output dcache_pkg::addr_t               req_addr_o,
  input  logic                            hit_i,
  output logic                            wr_en_o,
  output logic [dcache_pkg::STRB_W-1:0]   wr_strb_o,
  output logic [dcache_pkg::DATA_W-1:0]   wr_data_o,
  input  logic [dcache_pkg::DATA_W-1:0]   rd_data_i,
  // memory port
  output logic                            miss_o,
  input  logic                            fill_done_i
);

  localparam logic [2:0] S_IDLE    = 3'd0;
  localparam logic [2:0] S_LOOKUP  = 3'd1;
  localparam logic [2:0] S_MISS    = 3'd2;
  localparam logic [2:0] S_RD_RESP = 3'd3;
  localparam logic [2:0] S_WR_DATA = 3'd4;
  localparam logic [2:0] S_WR_RESP = 3'd5;

  logic [2:0] state_q;
  logic       is_wr_q;
  logic       ar_fire;
  logic       aw_fire;

  assign ar_fire = ar_valid_i & ar_ready_o;
  assign aw_fire = aw_valid_i & aw_ready_o & ~ar_valid_i;  // read wins

  // write merge happens on the w handshake itself
  assign wr_en_o   = w_valid_i & w_ready_o;
  assign wr_strb_o = w_strb_i;
  assign wr_data_o = w_data_i;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= S_IDLE;
      is_wr_q    <= 1'b0;
      ar_ready_o <= 1'b0;
      aw_ready_o <= 1'b0;
      r_valid_o  <= 1'b0;
      w_ready_o  <= 1'b0;
      b_valid_o  <= 1'b0;
      lookup_o   <= 1'b0;
      miss_o     <= 1'b0;
    end else begin
      lookup_o <= 1'b0;
      miss_o   <= 1'b0;
      case (state_q)
        S_IDLE: begin
          if (ar_fire || aw_fire) begin
            ar_ready_o <= 1'b0;
            aw_ready_o <= 1'b0;
            is_wr_q    <= ~ar_fire;
            lookup_o   <= 1'b1;
            state_q    <= S_LOOKUP;
          end else begin
            ar_ready_o <= 1'b1;
            aw_ready_o <= 1'b1;
          end
        end
        S_LOOKUP: begin
          // hit_i is only meaningful once the lookup pulse is gone
          if (!lookup_o) begin
            if (!hit_i) begin
              miss_o  <= 1'b1;
              state_q <= S_MISS;
            end else if (is_wr_q) begin
              w_ready_o <= 1'b1;
              state_q   <= S_WR_DATA;
            end else begin
              r_valid_o <= 1'b1;
              state_q   <= S_RD_RESP;
            end
          end
        end
        S_MISS: begin
          if (fill_done_i) begin
            lookup_o <= 1'b1;  // retry, line is now resident
            state_q  <= S_LOOKUP;
          end
        end
        S_RD_RESP: begin
          if (r_ready_i) begin
            r_valid_o  <= 1'b0;
            ar_ready_o <= 1'b1;
            aw_ready_o <= 1'b1;
            state_q    <= S_IDLE;
          end
        end
        S_WR_DATA: begin
          if (w_valid_i) begin
            w_ready_o <= 1'b0;
            b_valid_o <= 1'b1;
            state_q   <= S_WR_RESP;
          end
        end
        S_WR_RESP: begin
          if (b_ready_i) begin
            b_valid_o  <= 1'b0;
            ar_ready_o <= 1'b1;
            aw_ready_o <= 1'b1;
            state_q    <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // request address and read word
  always_ff @(posedge clk) begin
    if (ar_fire) begin
      req_addr_o.raw <= ar_addr_i;
    end else if (aw_fire) begin
      req_addr_o.raw <= aw_addr_i;
    end
    if (state_q == S_LOOKUP && !lookup_o && hit_i && !is_wr_q) begin
      r_data_o <= rd_data_i;
    end
  end

endmodule

//--- design/dcache_mem_port.sv
// memory side burst engine
module dcache_mem_port (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            miss_i,
  input  dcache_pkg::addr_t               miss_addr_i,
  input  logic                            victim_dirty_i,
  input  logic [dcache_pkg::TAG_W-1:0]    victim_tag_i,
  input  logic [dcache_pkg::DATA_W-1:0]   wb_data_i,
  output logic                            fill_done_o,
  output logic                            fill_we_o,
  output logic                            beat_o,
  output logic [dcache_pkg::DATA_W-1:0]   fill_data_o,
  output logic                            wb_done_o,
  // memory bus
  output logic                            mem_ar_valid_o,
  input  logic                            mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]   mem_ar_addr_o,
  input  logic                            mem_r_valid_i,
  output logic                            mem_r_ready_o,
  input  logic [dcache_pkg::DATA_W-1:0]   mem_r_data_i,
  output logic                            mem_aw_valid_o,
  input  logic                            mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]   mem_aw_addr_o,
  output logic                            mem_w_valid_o,
  input  logic                            mem_w_ready_i,
  output logic [dcache_pkg::STRB_W-1:0]   mem_w_strb_o,
  output logic [dcache_pkg::DATA_W-1:0]   mem_w_data_o,
  input  logic                            mem_b_valid_i,
  output logic                            mem_b_ready_o
);

  localparam logic [2:0] S_IDLE  = 3'd0;
  localparam logic [2:0] S_WB_AW = 3'd1;
  localparam logic [2:0] S_WB_W  = 3'd2;
  localparam logic [2:0] S_WB_B  = 3'd3;
  localparam logic [2:0] S_RF_AR = 3'd4;
  localparam logic [2:0] S_RF_R  = 3'd5;

  logic [2:0]        state_q;
  logic              beat_q;
  logic              last_beat;
  dcache_pkg::addr_t fill_addr;
  dcache_pkg::addr_t wb_addr;

  assign last_beat = (beat_q == 1'(dcache_pkg::BEATS - 1));

  always_comb begin
    fill_addr          = miss_addr_i;
    fill_addr.f.offset = '0;          // line aligned
    wb_addr.f.tag      = victim_tag_i;
    wb_addr.f.index    = miss_addr_i.f.index;
    wb_addr.f.offset   = '0;
  end

  assign beat_o       = beat_q;
  assign fill_we_o    = mem_r_valid_i & mem_r_ready_o;
  assign fill_data_o  = mem_r_data_i;
  assign wb_done_o    = mem_b_valid_i & mem_b_ready_o;
  assign mem_w_data_o = wb_data_i;
  assign mem_w_strb_o = '1;           // whole line goes back

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q        <= S_IDLE;
      beat_q         <= 1'b0;
      fill_done_o    <= 1'b0;
      mem_ar_valid_o <= 1'b0;
      mem_r_ready_o  <= 1'b0;
      mem_aw_valid_o <= 1'b0;
      mem_w_valid_o  <= 1'b0;
      mem_b_ready_o  <= 1'b0;
    end else begin
      fill_done_o <= 1'b0;
      case (state_q)
        S_IDLE: begin
          beat_q <= 1'b0;
          if (miss_i && victim_dirty_i) begin
            mem_aw_valid_o <= 1'b1;
            state_q        <= S_WB_AW;
          end else if (miss_i) begin
            mem_ar_valid_o <= 1'b1;
            state_q        <= S_RF_AR;
          end
        end
        S_WB_AW: if (mem_aw_ready_i) begin
          mem_aw_valid_o <= 1'b0;
          mem_w_valid_o  <= 1'b1;
          state_q        <= S_WB_W;
        end
        S_WB_W: if (mem_w_ready_i) begin
          beat_q <= ~last_beat;
          if (last_beat) begin
            mem_w_valid_o <= 1'b0;
            mem_b_ready_o <= 1'b1;
            state_q       <= S_WB_B;
          end
        end
        S_WB_B: if (mem_b_valid_i) begin
          mem_b_ready_o  <= 1'b0;
          mem_ar_valid_o <= 1'b1;  // now refill
          state_q        <= S_RF_AR;
        end
        S_RF_AR: if (mem_ar_ready_i) begin
          mem_ar_valid_o <= 1'b0;
          mem_r_ready_o  <= 1'b1;
          state_q        <= S_RF_R;
        end
        S_RF_R: if (mem_r_valid_i) begin
          beat_q <= ~last_beat;
          if (last_beat) begin
            mem_r_ready_o <= 1'b0;
            fill_done_o   <= 1'b1;
            state_q       <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // burst addresses
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && miss_i) begin
      mem_aw_addr_o <= wb_addr.raw;
      mem_ar_addr_o <= fill_addr.raw;
    end
  end

endmodule

//--- design/dcache_pkg.sv
// data cache geometry
package dcache_pkg;

  localparam int TAG_W    = 22;
  localparam int INDEX_W  = 6;
  localparam int OFFSET_W = 4;
  localparam int ADDR_W   = TAG_W + INDEX_W + OFFSET_W;

  localparam int SETS  = 1 << INDEX_W;
  localparam int WAYS  = 2;

  localparam int DATA_W = 64;
  localparam int STRB_W = DATA_W / 8;
  localparam int BEATS  = 2;    // beats per line
  localparam int LINE_W = DATA_W * BEATS;

  // address seen as a whole word or split into cache fields
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [TAG_W-1:0]    tag;
      logic [INDEX_W-1:0]  index;
      logic [OFFSET_W-1:0] offset;
    } f;
  } addr_t;

endpackage

//--- design/dcache_store.sv
// tag and data store
module dcache_store (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            lookup_i,
  input  dcache_pkg::addr_t               req_addr_i,
  input  logic                            wr_en_i,
  input  logic [dcache_pkg::STRB_W-1:0]   wr_strb_i,
  input  logic [dcache_pkg::DATA_W-1:0]   wr_data_i,
  input  logic                            fill_we_i,
  input  logic                            beat_i,
  input  logic [dcache_pkg::DATA_W-1:0]   fill_data_i,
  input  logic                            wb_done_i,
  output logic                            hit_o,
  output logic [dcache_pkg::DATA_W-1:0]   rd_data_o,
  output logic                            victim_dirty_o,
  output logic [dcache_pkg::TAG_W-1:0]    victim_tag_o,
  output logic [dcache_pkg::DATA_W-1:0]   wb_data_o
);

  logic [dcache_pkg::TAG_W-1:0]  tag_q  [dcache_pkg::WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::LINE_W-1:0] data_q [dcache_pkg::WAYS][dcache_pkg::SETS];
  logic [dcache_pkg::WAYS-1:0][dcache_pkg::SETS-1:0] valid_q;
  logic [dcache_pkg::WAYS-1:0][dcache_pkg::SETS-1:0] dirty_q;

  dcache_pkg::addr_t              addr_q;
  logic                           way_q;    // selected way of last lookup
  logic                           rnd_q;    // free-running victim pick
  logic [dcache_pkg::WAYS-1:0]    way_hit;
  logic [dcache_pkg::INDEX_W-1:0] idx;
  logic                           word_sel;
  logic [dcache_pkg::LINE_W-1:0]  cur_line;
  logic [dcache_pkg::LINE_W-1:0]  new_line;

  assign idx      = addr_q.f.index;
  assign word_sel = addr_q.f.offset[dcache_pkg::OFFSET_W-1];
  assign cur_line = data_q[way_q][idx];

  always_comb begin
    for (int w = 0; w < dcache_pkg::WAYS; w++) begin
      way_hit[w] = valid_q[w][req_addr_i.f.index] &&
                   (tag_q[w][req_addr_i.f.index] == req_addr_i.f.tag);
    end
  end

  // refill beat or strobed cpu write
  always_comb begin
    new_line = cur_line;
    if (fill_we_i) begin
      new_line[beat_i*dcache_pkg::DATA_W +: dcache_pkg::DATA_W] = fill_data_i;
    end else begin
      for (int b = 0; b < dcache_pkg::STRB_W; b++) begin
        if (wr_strb_i[b]) begin
          new_line[word_sel*dcache_pkg::DATA_W + b*8 +: 8] = wr_data_i[b*8 +: 8];
        end
      end
    end
  end

  assign rd_data_o = word_sel ? cur_line[dcache_pkg::LINE_W-1:dcache_pkg::DATA_W]
                              : cur_line[dcache_pkg::DATA_W-1:0];
  assign wb_data_o = beat_i ? cur_line[dcache_pkg::LINE_W-1:dcache_pkg::DATA_W]
                            : cur_line[dcache_pkg::DATA_W-1:0];

  assign victim_dirty_o = valid_q[way_q][idx] & dirty_q[way_q][idx];
  assign victim_tag_o   = tag_q[way_q][idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      hit_o   <= 1'b0;
      way_q   <= 1'b0;
      rnd_q   <= 1'b0;
      valid_q <= '0;
      dirty_q <= '0;
    end else begin
      rnd_q <= rnd_q + 1'b1;
      if (lookup_i) begin
        hit_o <= |way_hit;
        way_q <= way_hit[1] ? 1'b1 : (way_hit[0] ? 1'b0 : rnd_q);
      end
      if (wr_en_i) begin
        dirty_q[way_q][idx] <= 1'b1;
      end
      if (fill_we_i && beat_i) begin  // last beat completes the line
        valid_q[way_q][idx] <= 1'b1;
        dirty_q[way_q][idx] <= 1'b0;
      end
      if (wb_done_i) begin
        dirty_q[way_q][idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (lookup_i) begin
      addr_q <= req_addr_i;
    end
    if (wr_en_i || fill_we_i) begin
      data_q[way_q][idx] <= new_line;
    end
    if (fill_we_i && beat_i) begin
      tag_q[way_q][idx] <= addr_q.f.tag;
    end
  end

endmodule

//--- design/dcache_top.sv
// write-back data cache top
module dcache_top (
  input  logic                            clk,
  input  logic                            rst,
  // cpu side
  input  logic                            ar_valid_i,
  output logic                            ar_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0]   ar_addr_i,
  output logic                            r_valid_o,
  input  logic                            r_ready_i,
  output logic [dcache_pkg::DATA_W-1:0]   r_data_o,
  input  logic                            aw_valid_i,
  output logic                            aw_ready_o,
  input  logic [dcache_pkg::ADDR_W-1:0]   aw_addr_i,
  input  logic                            w_valid_i,
  output logic                            w_ready_o,
  input  logic [dcache_pkg::STRB_W-1:0]   w_strb_i,
  input  logic [dcache_pkg::DATA_W-1:0]   w_data_i,
  output logic                            b_valid_o,
  input  logic                            b_ready_i,
  // memory side
  output logic                            mem_ar_valid_o,
  input  logic                            mem_ar_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]   mem_ar_addr_o,
  input  logic                            mem_r_valid_i,
  output logic                            mem_r_ready_o,
  input  logic [dcache_pkg::DATA_W-1:0]   mem_r_data_i,
  output logic                            mem_aw_valid_o,
  input  logic                            mem_aw_ready_i,
  output logic [dcache_pkg::ADDR_W-1:0]   mem_aw_addr_o,
  output logic                            mem_w_valid_o,
  input  logic                            mem_w_ready_i,
  output logic [dcache_pkg::STRB_W-1:0]   mem_w_strb_o,
  output logic [dcache_pkg::DATA_W-1:0]   mem_w_data_o,
  input  logic                            mem_b_valid_i,
  output logic                            mem_b_ready_o
);

  dcache_pkg::addr_t            req_addr;
  logic                         lookup;
  logic                         hit;
  logic                         wr_en;
  logic [dcache_pkg::STRB_W-1:0] wr_strb;
  logic [dcache_pkg::DATA_W-1:0] wr_data;
  logic [dcache_pkg::DATA_W-1:0] rd_data;
  logic                         miss;
  logic                         fill_done;
  logic                         victim_dirty;
  logic [dcache_pkg::TAG_W-1:0]  victim_tag;
  logic [dcache_pkg::DATA_W-1:0] wb_data;
  logic                         fill_we;
  logic                         beat;
  logic [dcache_pkg::DATA_W-1:0] fill_data;
  logic                         wb_done;

  // cpu ports share names with the top, so .* picks them up
  dcache_front i_front (
    .*,
    .lookup_o    (lookup),
    .req_addr_o  (req_addr),
    .hit_i       (hit),
    .wr_en_o     (wr_en),
    .wr_strb_o   (wr_strb),
    .wr_data_o   (wr_data),
    .rd_data_i   (rd_data),
    .miss_o      (miss),
    .fill_done_i (fill_done)
  );

  dcache_store i_store (
    .clk            (clk),
    .rst            (rst),
    .lookup_i       (lookup),
    .req_addr_i     (req_addr),
    .wr_en_i        (wr_en),
    .wr_strb_i      (wr_strb),
    .wr_data_i      (wr_data),
    .fill_we_i      (fill_we),
    .beat_i         (beat),
    .fill_data_i    (fill_data),
    .wb_done_i      (wb_done),
    .hit_o          (hit),
    .rd_data_o      (rd_data),
    .victim_dirty_o (victim_dirty),
    .victim_tag_o   (victim_tag),
    .wb_data_o      (wb_data)
  );

  dcache_mem_port i_mem_port (
    .*,
    .miss_i         (miss),
    .miss_addr_i    (req_addr),
    .victim_dirty_i (victim_dirty),
    .victim_tag_i   (victim_tag),
    .wb_data_i      (wb_data),
    .fill_done_o    (fill_done),
    .fill_we_o      (fill_we),
    .beat_o         (beat),
    .fill_data_o    (fill_data),
    .wb_done_o      (wb_done)
  );

endmodule

//--- verilog.f
design/dcache_pkg.sv
design/dcache_front.sv
design/dcache_store.sv
design/dcache_mem_port.sv
design/dcache_top.sv
bench/dcache_mem_model.sv
bench/dcache_tb.sv
